//--- sd_pkg.sv
// ===============================================
// Host block-device transport. Sectors are 512 bytes, moved as 256 words
// ===============================================
`default_nettype none

package sd_pkg;

	// Sector number on the host device
	typedef logic [31:0] lba_t;

	typedef logic [15:0] sector_word_t;

	// Word index inside one sector
	typedef logic [7:0] buff_addr_t;

	localparam int SECTOR_WORDS = 256;

	// Requester that owns the current host transfer
	typedef enum logic {
		CHAN_BACKUP = 1'b0,
		CHAN_DATA   = 1'b1
	} chan_t;

endpackage

`default_nettype wire

//--- snes_pkg.sv
// ===============================================
// Console-side types. bsram_addr_t is the widest RAM the hub supports
// ===============================================
`default_nettype none

package snes_pkg;

	typedef logic [7:0] byte_t;

	// Code 0 is no RAM, code n is 1024 << n bytes
	typedef logic [3:0] ram_size_t;

	// Default backup RAM address width, 128 KiB
	localparam int BSRAM_BITS = 17;

	typedef logic [BSRAM_BITS-1:0] bsram_addr_t;

	// Byte address into the data track
	typedef logic [31:0] msu_addr_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	typedef enum logic [2:0] {
		MSU_PAUSED,
		MSU_REQ,
		MSU_WAIT_ACK,
		MSU_XFER,
		MSU_TOPUP
	} msu_state_t;

endpackage

`default_nettype wire

//--- sector_if.sv
// ===============================================
// One requester's view of the host sector port
// ===============================================
`timescale 1ns/1ps
`default_nettype none

interface sector_if;

	// Request side, held until ack rises
	logic                 rd;
	logic                 wr;
	sd_pkg::lba_t         lba;

	// Burst side, only toggles for the granted requester
	logic                 ack;
	sd_pkg::buff_addr_t   buff_addr;
	sd_pkg::sector_word_t buff_dout;
	logic                 buff_wr;

	// Write-direction data, sampled by the host one cycle after buff_addr
	sd_pkg::sector_word_t buff_din;

	modport requester (
		output rd, wr, lba, buff_din,
		input  ack, buff_addr, buff_dout, buff_wr
	);

	modport arbiter (
		input  rd, wr, lba, buff_din,
		output ack, buff_addr, buff_dout, buff_wr
	);

endinterface

`default_nettype wire

//--- sector_arbiter.sv
// ===============================================
// Host must not raise ack in the same cycle it first sees sd_rd or sd_wr
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module sector_arbiter (
	input  wire                  clk_sys,
	input  wire                  reset,
	sector_if.arbiter            bk,
	sector_if.arbiter            msu,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output sd_pkg::lba_t         sd_lba,
	output sd_pkg::chan_t        sd_chan,
	input  wire                  sd_ack,
	input  wire sd_pkg::buff_addr_t   sd_buff_addr,
	input  wire sd_pkg::sector_word_t sd_buff_dout,
	input  wire                  sd_buff_wr,
	output sd_pkg::sector_word_t sd_buff_din
);

	logic          bk_req;
	logic          msu_req;
	logic          busy;
	logic          ack_d;
	logic          bk_own;
	logic          msu_own;
	sd_pkg::chan_t next_chan;

	assign bk_req  = bk.rd | bk.wr;
	assign msu_req = msu.rd | msu.wr;

	// sd_chan keeps the last owner, so the other side wins a tie
	always_comb begin
		if (bk_req && msu_req)
			next_chan = (sd_chan == sd_pkg::CHAN_BACKUP) ? sd_pkg::CHAN_DATA
				: sd_pkg::CHAN_BACKUP;
		else if (msu_req)
			next_chan = sd_pkg::CHAN_DATA;
		else
			next_chan = sd_pkg::CHAN_BACKUP;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			ack_d   <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			sd_chan <= sd_pkg::CHAN_BACKUP;
		end else begin
			ack_d <= sd_ack;
			if (sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (busy) begin
				// Grant ends on the ack fall
				if (ack_d && !sd_ack)
					busy <= 1'b0;
			end else if (bk_req || msu_req) begin
				busy    <= 1'b1;
				sd_chan <= next_chan;
				sd_rd   <= (next_chan == sd_pkg::CHAN_DATA) ? msu.rd : bk.rd;
				sd_wr   <= (next_chan == sd_pkg::CHAN_DATA) ? msu.wr : bk.wr;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!busy && (bk_req || msu_req))
			sd_lba <= (next_chan == sd_pkg::CHAN_DATA) ? msu.lba : bk.lba;
	end

	// ===============================================
	// Steering to the owner
	// ===============================================
	assign bk_own  = busy && (sd_chan == sd_pkg::CHAN_BACKUP);
	assign msu_own = busy && (sd_chan == sd_pkg::CHAN_DATA);

	assign bk.ack        = sd_ack && bk_own;
	assign bk.buff_wr    = sd_buff_wr && bk_own;
	assign bk.buff_addr  = bk_own ? sd_buff_addr : '0;
	assign bk.buff_dout  = sd_buff_dout;
	assign msu.ack       = sd_ack && msu_own;
	assign msu.buff_wr   = sd_buff_wr && msu_own;
	assign msu.buff_addr = msu_own ? sd_buff_addr : '0;
	assign msu.buff_dout = sd_buff_dout;

	// Write data lags buff_addr by one cycle, sd_chan still holds the owner
	assign sd_buff_din = (sd_chan == sd_pkg::CHAN_DATA) ? msu.buff_din : bk.buff_din;

	a_grant_held: assert property (@(posedge clk_sys) disable iff (reset)
		sd_ack |-> $stable(sd_chan));

	a_one_direction: assert property (@(posedge clk_sys) disable iff (reset)
		!(bk.rd && bk.wr) && !(msu.rd && msu.wr));

endmodule

`default_nettype wire

//--- backup_ram.sv
// ===============================================
// Both ports read with one cycle latency. Same-address writes collide
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module backup_ram #(
	parameter int BSRAM_BITS = 17
) (
	input  wire                       clk_sys,
	input  wire snes_pkg::bsram_addr_t cpu_addr,
	input  wire snes_pkg::byte_t      cpu_d,
	input  wire                       cpu_we,
	output snes_pkg::byte_t           cpu_q,
	input  wire sd_pkg::lba_t         sec_lba,
	input  wire sd_pkg::buff_addr_t   sec_addr,
	input  wire sd_pkg::sector_word_t sec_d,
	input  wire                       sec_we,
	output sd_pkg::sector_word_t      sec_q
);

	localparam int WORD_BITS = BSRAM_BITS - 1;
	localparam int WORDS     = 1 << WORD_BITS;

	logic [WORD_BITS-1:0] cpu_word;
	logic [WORD_BITS-1:0] sec_word;
	logic                 cpu_hi_d;
	snes_pkg::byte_t      cpu_bank_q [2];
	snes_pkg::byte_t      sec_bank_q [2];

	assign cpu_word = cpu_addr[BSRAM_BITS-1:1];
	assign sec_word = {sec_lba[BSRAM_BITS-10:0], sec_addr};

	// Bank 0 holds even bytes (word low half), bank 1 odd bytes
	for (genvar b = 0; b < 2; b++) begin : g_bank
		snes_pkg::byte_t mem [WORDS];

		always_ff @(posedge clk_sys) begin
			if (cpu_we && (cpu_addr[0] == b))
				mem[cpu_word] <= cpu_d;
			if (sec_we)
				mem[sec_word] <= sec_d[8*b +: 8];
			cpu_bank_q[b] <= mem[cpu_word];
			sec_bank_q[b] <= mem[sec_word];
		end
	end

	always_ff @(posedge clk_sys) begin
		cpu_hi_d <= cpu_addr[0];
	end

	assign cpu_q = cpu_bank_q[cpu_hi_d];
	assign sec_q = {sec_bank_q[1], sec_bank_q[0]};

endmodule

`default_nettype wire

//--- backup_sync.sv
// ===============================================
// Load wins if load and save rise together. Sizes past the RAM are clipped
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module backup_sync #(
	parameter int BSRAM_BITS = 17
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	sector_if.requester             sec,
	input  wire snes_pkg::ram_size_t ram_size,
	input  wire                     bk_ena,
	input  wire                     bk_load,
	input  wire                     bk_save,
	input  wire                     cpu_we,
	output logic                    bk_busy,
	output logic                    bk_pending,
	output sd_pkg::lba_t            ram_lba,
	output logic                    ram_we
);

	// Last sector the RAM itself can hold
	localparam sd_pkg::lba_t MAX_LBA = sd_pkg::lba_t'((1 << (BSRAM_BITS - 9)) - 1);

	snes_pkg::bk_state_t state;
	sd_pkg::lba_t        lba;
	sd_pkg::lba_t        size_lba;
	sd_pkg::lba_t        last_lba;
	logic                old_load;
	logic                old_save;
	logic                old_ack;
	logic                loading;
	logic                load_edge;
	logic                save_edge;
	logic                start;

	assign load_edge = bk_load && !old_load;
	assign save_edge = bk_save && !old_save;
	assign start     = (state == snes_pkg::BK_IDLE) && bk_ena && (ram_size != '0)
		&& (load_edge || save_edge);

	// (1024 << n) / 512 - 1
	assign size_lba = (sd_pkg::lba_t'(2) << ram_size) - 1'b1;
	assign last_lba = (size_lba > MAX_LBA) ? MAX_LBA : size_lba;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state    <= snes_pkg::BK_IDLE;
			lba      <= '0;
			loading  <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			bk_busy  <= 1'b0;
			sec.rd   <= 1'b0;
			sec.wr   <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sec.ack;
			if (sec.ack) begin
				sec.rd <= 1'b0;
				sec.wr <= 1'b0;
			end
			case (state)
				snes_pkg::BK_IDLE: if (start) begin
					loading <= load_edge;
					lba     <= '0;
					sec.rd  <= load_edge;
					sec.wr  <= !load_edge;
					bk_busy <= 1'b1;
					state   <= snes_pkg::BK_XFER;
				end
				snes_pkg::BK_XFER: if (old_ack && !sec.ack) begin
					if (lba >= last_lba) begin
						bk_busy <= 1'b0;
						state   <= snes_pkg::BK_IDLE;
					end else begin
						lba    <= lba + 1'b1;
						sec.rd <= loading;
						sec.wr <= !loading;
					end
				end
			endcase
		end
	end

	// CPU writes mark the RAM dirty until the next save
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			bk_pending <= 1'b0;
		else if (start && !load_edge)
			bk_pending <= 1'b0;
		else if (cpu_we && bk_ena)
			bk_pending <= 1'b1;
	end

	assign sec.lba = lba;
	assign ram_lba = lba;
	// Host words land in the RAM only during a load
	assign ram_we  = loading && sec.ack && sec.buff_wr;

	a_busy_state: assert property (@(posedge clk_sys) disable iff (reset)
		bk_busy == (state == snes_pkg::BK_XFER));

endmodule

`default_nettype wire

//--- msu_data_fifo.sv
// ===============================================
// Show-ahead FIFO, rdata is valid whenever empty is low
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module msu_data_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 11
) (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       clear,
	input  wire                       wr,
	input  wire sd_pkg::sector_word_t wdata,
	input  wire                       rd,
	output sd_pkg::sector_word_t      rdata,
	output logic [FIFO_DEPTH_LOG2:0]  count,
	output logic                      full,
	output logic                      empty
);

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	sd_pkg::sector_word_t       mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr)
			mem[wr_ptr] <= wdata;
	end

	assign rdata = mem[rd_ptr];
	assign full  = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
	assign empty = (count == '0);

	a_no_underflow: assert property (@(posedge clk_sys) disable iff (reset)
		rd && !clear |-> !empty);

	a_no_overflow: assert property (@(posedge clk_sys) disable iff (reset)
		wr && !clear |-> !full);

endmodule

`default_nettype wire

//--- msu_data_reader.sv
// ===============================================
// Read only. A seek during a transfer takes effect once that sector ends
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module msu_data_reader #(
	parameter int FIFO_DEPTH_LOG2 = 11,
	parameter int FILL_SECTORS    = 4
) (
	input  wire                      clk_sys,
	input  wire                      reset,
	sector_if.requester              sec,
	input  wire                      msu_seek,
	input  wire snes_pkg::msu_addr_t msu_addr,
	input  wire                      msu_data_req,
	output snes_pkg::byte_t          msu_data,
	output logic                     msu_data_busy
);

	localparam int CNT_BITS    = FIFO_DEPTH_LOG2 + 1;
	localparam int LOADED_BITS = $clog2(FILL_SECTORS + 1);
	// Below this level a whole sector still fits
	localparam logic [CNT_BITS-1:0] TOPUP_LEVEL =
		CNT_BITS'((1 << FIFO_DEPTH_LOG2) - sd_pkg::SECTOR_WORDS);

	snes_pkg::msu_state_t   state;
	sd_pkg::lba_t           lba;
	snes_pkg::msu_addr_t    seek_addr;
	logic [LOADED_BITS-1:0] loaded;
	logic [CNT_BITS-1:0]    fifo_count;
	sd_pkg::sector_word_t   fifo_head;
	logic                   seek_old;
	logic                   seek_pend;
	logic                   first_sec;
	logic                   old_ack;
	logic                   bit1_old;
	logic                   seek_apply;
	logic                   room;
	logic                   fifo_wr;
	logic                   fifo_rd;

	// Apply a seek only when no sector is outstanding
	assign seek_apply = seek_pend && (state != snes_pkg::MSU_WAIT_ACK)
		&& (state != snes_pkg::MSU_XFER);
	assign room = fifo_count < TOPUP_LEVEL;

	// Words ahead of the seek address in its own sector are dropped
	assign fifo_wr = sec.ack && sec.buff_wr
		&& (!first_sec || (sec.buff_addr >= seek_addr[8:1]));
	// Pop on each word boundary crossed by the console
	assign fifo_rd = msu_data_req && (msu_addr[1] != bit1_old);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state         <= snes_pkg::MSU_PAUSED;
			lba           <= '0;
			loaded        <= '0;
			seek_old      <= 1'b0;
			seek_pend     <= 1'b0;
			first_sec     <= 1'b0;
			old_ack       <= 1'b0;
			bit1_old      <= 1'b0;
			msu_data_busy <= 1'b0;
			sec.rd        <= 1'b0;
		end else begin
			seek_old <= msu_seek;
			old_ack  <= sec.ack;
			bit1_old <= msu_addr[1];
			if (seek_apply) begin
				seek_pend <= 1'b0;
				lba       <= sd_pkg::lba_t'(seek_addr[31:9]);
				first_sec <= 1'b1;
				loaded    <= '0;
				state     <= snes_pkg::MSU_REQ;
			end else begin
				case (state)
					snes_pkg::MSU_REQ: begin
						sec.rd <= 1'b1;
						state  <= snes_pkg::MSU_WAIT_ACK;
					end
					snes_pkg::MSU_WAIT_ACK: if (sec.ack) begin
						sec.rd <= 1'b0;
						state  <= snes_pkg::MSU_XFER;
					end
					snes_pkg::MSU_XFER: if (old_ack && !sec.ack) begin
						first_sec <= 1'b0;
						if (msu_data_busy)
							loaded <= loaded + 1'b1;
						if (msu_data_busy && !seek_pend
							&& (loaded == LOADED_BITS'(FILL_SECTORS - 1)))
							msu_data_busy <= 1'b0;
						if (room) begin
							lba   <= lba + 1'b1;
							state <= snes_pkg::MSU_REQ;
						end else begin
							state <= snes_pkg::MSU_TOPUP;
						end
					end
					snes_pkg::MSU_TOPUP: if (room) begin
						lba   <= lba + 1'b1;
						state <= snes_pkg::MSU_REQ;
					end
					default: ;
				endcase
			end
			// Seek edge, overrides the busy release above
			if (msu_seek && !seek_old) begin
				seek_pend     <= 1'b1;
				msu_data_busy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (msu_seek && !seek_old)
			seek_addr <= msu_addr;
	end

	msu_data_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) msu_data_fifo_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.clear(seek_apply),
		.wr(fifo_wr),
		.wdata(sec.buff_dout),
		.rd(fifo_rd),
		.rdata(fifo_head),
		.count(fifo_count),
		.full(),
		.empty()
	);

	assign msu_data     = msu_addr[0] ? fifo_head[15:8] : fifo_head[7:0];
	assign sec.lba      = lba;
	assign sec.wr       = 1'b0;
	assign sec.buff_din = '0;

endmodule

`default_nettype wire

//--- snes_sd_hub.sv
// ===============================================
// Backup RAM and data track share one host sector port
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module snes_sd_hub #(
	parameter int BSRAM_BITS      = snes_pkg::BSRAM_BITS,
	parameter int FIFO_DEPTH_LOG2 = 11,
	parameter int FILL_SECTORS    = 4
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	// Host sector port
	output logic                       sd_rd,
	output logic                       sd_wr,
	output sd_pkg::lba_t               sd_lba,
	output sd_pkg::chan_t              sd_chan,
	input  wire                        sd_ack,
	input  wire sd_pkg::buff_addr_t    sd_buff_addr,
	input  wire sd_pkg::sector_word_t  sd_buff_dout,
	input  wire                        sd_buff_wr,
	output sd_pkg::sector_word_t       sd_buff_din,
	// CPU side of backup RAM
	input  wire snes_pkg::bsram_addr_t bsram_addr,
	input  wire snes_pkg::byte_t       bsram_d,
	input  wire                        bsram_we,
	output snes_pkg::byte_t            bsram_q,
	// Backup control
	input  wire snes_pkg::ram_size_t   ram_size,
	input  wire                        bk_ena,
	input  wire                        bk_load,
	input  wire                        bk_save,
	output logic                       bk_busy,
	output logic                       bk_pending,
	// Data track
	input  wire                        msu_seek,
	input  wire snes_pkg::msu_addr_t   msu_addr,
	input  wire                        msu_data_req,
	output snes_pkg::byte_t            msu_data,
	output logic                       msu_data_busy
);

	sector_if bk_if ();
	sector_if msu_if ();

	sd_pkg::lba_t ram_lba;
	logic         ram_we;

	backup_ram #(
		.BSRAM_BITS(BSRAM_BITS)
	) backup_ram_inst (
		.clk_sys(clk_sys),
		.cpu_addr(bsram_addr),
		.cpu_d(bsram_d),
		.cpu_we(bsram_we),
		.cpu_q(bsram_q),
		.sec_lba(ram_lba),
		.sec_addr(bk_if.buff_addr),
		.sec_d(bk_if.buff_dout),
		.sec_we(ram_we),
		.sec_q(bk_if.buff_din)
	);

	backup_sync #(
		.BSRAM_BITS(BSRAM_BITS)
	) backup_sync_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.sec(bk_if.requester),
		.ram_size(ram_size),
		.bk_ena(bk_ena),
		.bk_load(bk_load),
		.bk_save(bk_save),
		.cpu_we(bsram_we),
		.bk_busy(bk_busy),
		.bk_pending(bk_pending),
		.ram_lba(ram_lba),
		.ram_we(ram_we)
	);

	msu_data_reader #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.FILL_SECTORS(FILL_SECTORS)
	) msu_data_reader_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.sec(msu_if.requester),
		.msu_seek(msu_seek),
		.msu_addr(msu_addr),
		.msu_data_req(msu_data_req),
		.msu_data(msu_data),
		.msu_data_busy(msu_data_busy)
	);

	sector_arbiter sector_arbiter_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.bk(bk_if.arbiter),
		.msu(msu_if.arbiter),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_lba(sd_lba),
		.sd_chan(sd_chan),
		.sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr),
		.sd_buff_din(sd_buff_din)
	);

endmodule

`default_nettype wire

//--- tb_snes_sd_hub.sv
// ==================================================
// Host sector model serves backup images and a random data track
// Runs with the top level's default parameters and an 8 KiB backup RAM
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_snes_sd_hub;

	localparam int RAM_CODE      = 3;
	localparam int RAM_BYTES     = 1024 << RAM_CODE;
	localparam int SECTORS       = RAM_BYTES / 512;
	localparam int FILL_SECTORS  = 4;
	localparam int MAX_DELAY     = 8;
	localparam int FILE_WORDS    = 64 * sd_pkg::SECTOR_WORDS;
	localparam int STREAM_FIRST  = 3000;
	localparam int STREAM_SECOND = 4000;
	localparam int SECTOR_CYCLES = sd_pkg::SECTOR_WORDS + MAX_DELAY + 8;
	localparam int WAIT_LIMIT    = 4 * SECTORS * SECTOR_CYCLES;
	localparam int SECTOR_BUDGET = 4 * SECTORS + (STREAM_FIRST + STREAM_SECOND) / 512 + 16;
	localparam int WATCHDOG_CYCLES = 2 * (3 * RAM_BYTES + STREAM_FIRST + STREAM_SECOND
		+ SECTOR_BUDGET * SECTOR_CYCLES);

	logic                  clk_sys;
	logic                  reset;
	logic                  sd_rd;
	logic                  sd_wr;
	sd_pkg::lba_t          sd_lba;
	sd_pkg::chan_t         sd_chan;
	logic                  sd_ack;
	sd_pkg::buff_addr_t    sd_buff_addr;
	sd_pkg::sector_word_t  sd_buff_dout;
	logic                  sd_buff_wr;
	sd_pkg::sector_word_t  sd_buff_din;
	snes_pkg::bsram_addr_t bsram_addr;
	snes_pkg::byte_t       bsram_d;
	logic                  bsram_we;
	snes_pkg::byte_t       bsram_q;
	snes_pkg::ram_size_t   ram_size;
	logic                  bk_ena;
	logic                  bk_load;
	logic                  bk_save;
	logic                  bk_busy;
	logic                  bk_pending;
	logic                  msu_seek;
	snes_pkg::msu_addr_t   msu_addr;
	logic                  msu_data_req;
	snes_pkg::byte_t       msu_data;
	logic                  msu_data_busy;

	// Reference state
	snes_pkg::byte_t      model_ram [RAM_BYTES];
	sd_pkg::sector_word_t image [SECTORS * sd_pkg::SECTOR_WORDS];
	sd_pkg::sector_word_t file_tab [FILE_WORDS];
	sd_pkg::lba_t         msu_next_lba = '0;
	logic                 load_active = 1'b0;
	int                   bk_wr_sectors = 0;
	int                   bk_rd_sectors = 0;
	int                   msu_sectors = 0;
	int                   checks = 0;
	int                   errors = 0;

	snes_sd_hub snes_sd_hub_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_lba(sd_lba),
		.sd_chan(sd_chan),
		.sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr),
		.sd_buff_din(sd_buff_din),
		.bsram_addr(bsram_addr),
		.bsram_d(bsram_d),
		.bsram_we(bsram_we),
		.bsram_q(bsram_q),
		.ram_size(ram_size),
		.bk_ena(bk_ena),
		.bk_load(bk_load),
		.bk_save(bk_save),
		.bk_busy(bk_busy),
		.bk_pending(bk_pending),
		.msu_seek(msu_seek),
		.msu_addr(msu_addr),
		.msu_data_req(msu_data_req),
		.msu_data(msu_data),
		.msu_data_busy(msu_data_busy)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_byte(input string name, input snes_pkg::byte_t got,
		input snes_pkg::byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_word(input string name, input sd_pkg::sector_word_t got,
		input sd_pkg::sector_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_lba(input string name, input sd_pkg::lba_t got,
		input sd_pkg::lba_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_chan(input string name, input sd_pkg::chan_t got,
		input sd_pkg::chan_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR: %s moved %0d sectors instead of %0d", what, got, exp);
		end
	endtask

	// ==================================================
	// Reference models
	// ==================================================
	// Word k of sector s holds bytes 512s+2k (low) and 512s+2k+1 (high)
	function automatic sd_pkg::sector_word_t save_word(input sd_pkg::lba_t lba, input int k);
		int idx;
		idx = int'((lba * 512 + 2 * k) % RAM_BYTES);
		return {model_ram[idx + 1], model_ram[idx]};
	endfunction

	function automatic sd_pkg::sector_word_t load_word(input sd_pkg::lba_t lba, input int k);
		return image[int'(lba % SECTORS) * sd_pkg::SECTOR_WORDS + k];
	endfunction

	function automatic sd_pkg::sector_word_t file_word(input sd_pkg::lba_t lba, input int k);
		return file_tab[int'(lba[5:0]) * sd_pkg::SECTOR_WORDS + k];
	endfunction

	function automatic snes_pkg::byte_t stream_byte(input snes_pkg::msu_addr_t addr);
		sd_pkg::sector_word_t w;
		w = file_word(addr >> 9, int'(addr[8:1]));
		return addr[0] ? w[15:8] : w[7:0];
	endfunction

	// ==================================================
	// Host sector model
	// ==================================================
	task automatic serve_sector();
		sd_pkg::lba_t  lba;
		sd_pkg::chan_t owner;
		logic          is_wr;
		lba   = sd_lba;
		is_wr = sd_wr;
		owner = (is_wr || load_active) ? sd_pkg::CHAN_BACKUP : sd_pkg::CHAN_DATA;
		check_chan("sd_chan", sd_chan, owner);
		if (is_wr)
			check_lba("sd_lba", lba, sd_pkg::lba_t'(bk_wr_sectors));
		else if (owner == sd_pkg::CHAN_BACKUP)
			check_lba("sd_lba", lba, sd_pkg::lba_t'(bk_rd_sectors));
		else
			check_lba("sd_lba", lba, msu_next_lba);
		repeat (1 + $urandom % MAX_DELAY) @(negedge clk_sys);
		if (is_wr) begin
			// Write data shows up one cycle after the word address
			sd_ack       = 1'b1;
			sd_buff_addr = '0;
			for (int k = 0; k < sd_pkg::SECTOR_WORDS; k++) begin
				@(negedge clk_sys);
				check_word("sd_buff_din", sd_buff_din, save_word(lba, k));
				sd_buff_addr = sd_pkg::buff_addr_t'(k + 1);
			end
			sd_ack = 1'b0;
			bk_wr_sectors++;
		end else begin
			for (int k = 0; k < sd_pkg::SECTOR_WORDS; k++) begin
				sd_ack       = 1'b1;
				sd_buff_wr   = 1'b1;
				sd_buff_addr = sd_pkg::buff_addr_t'(k);
				sd_buff_dout = (owner == sd_pkg::CHAN_BACKUP) ? load_word(lba, k)
					: file_word(lba, k);
				@(negedge clk_sys);
			end
			sd_ack     = 1'b0;
			sd_buff_wr = 1'b0;
			if (owner == sd_pkg::CHAN_BACKUP) begin
				bk_rd_sectors++;
			end else begin
				msu_sectors++;
				msu_next_lba++;
			end
		end
	endtask

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_rd || sd_wr))
				serve_sector();
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && sd_rd && sd_wr) begin
			errors++;
			$display("ERROR: sd_rd and sd_wr are high together at %0t", $time);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d errors %0d", checks, errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

	// ==================================================
	// Console-side stimulus
	// ==================================================
	task automatic cpu_write(input snes_pkg::bsram_addr_t addr, input snes_pkg::byte_t data);
		bsram_addr = addr;
		bsram_d    = data;
		bsram_we   = 1'b1;
		model_ram[int'(addr) % RAM_BYTES] = data;
		@(negedge clk_sys);
		bsram_we = 1'b0;
	endtask

	task automatic cpu_read(input snes_pkg::bsram_addr_t addr, input snes_pkg::byte_t exp);
		bsram_addr = addr;
		@(negedge clk_sys);
		check_byte("bsram_q", bsram_q, exp);
	endtask

	task automatic wait_bk_done(input string what);
		int n;
		n = 0;
		while (bk_busy && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy) begin
			errors++;
			$display("ERROR: bk_busy never fell during %s", what);
		end
	endtask

	task automatic wait_stream_ready();
		int n;
		n = 0;
		while (msu_data_busy && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (msu_data_busy) begin
			errors++;
			$display("ERROR: msu_data_busy never fell after the seek");
		end
	endtask

	task automatic run_save(input string what);
		bk_wr_sectors = 0;
		bk_save       = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		check_flag("bk_busy", bk_busy, 1'b1);
		wait_bk_done(what);
		check_count(what, bk_wr_sectors, SECTORS);
	endtask

	// Console reads one byte per cycle, a pop lands before the byte is sampled
	task automatic read_stream(input snes_pkg::msu_addr_t start, input int n);
		snes_pkg::msu_addr_t addr;
		addr = start;
		for (int i = 0; i < n; i++) begin
			msu_addr     = addr;
			msu_data_req = 1'b1;
			@(negedge clk_sys);
			msu_data_req = 1'b0;
			check_byte("msu_data", msu_data, stream_byte(addr));
			addr++;
		end
	endtask

	initial begin
		snes_pkg::msu_addr_t stream_addr;
		void'($urandom(32'ha161));
		reset        = 1'b1;
		bsram_addr   = '0;
		bsram_d      = '0;
		bsram_we     = 1'b0;
		ram_size     = '0;
		bk_ena       = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		msu_seek     = 1'b0;
		msu_addr     = '0;
		msu_data_req = 1'b0;
		for (int i = 0; i < FILE_WORDS; i++)
			file_tab[i] = sd_pkg::sector_word_t'($urandom);
		for (int i = 0; i < SECTORS * sd_pkg::SECTOR_WORDS; i++)
			image[i] = sd_pkg::sector_word_t'($urandom);
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_flag("sd_rd", sd_rd, 1'b0);
		check_flag("sd_wr", sd_wr, 1'b0);
		check_flag("bk_busy", bk_busy, 1'b0);
		check_flag("bk_pending", bk_pending, 1'b0);
		check_flag("msu_data_busy", msu_data_busy, 1'b0);

		// Save of a freshly written RAM
		ram_size = snes_pkg::ram_size_t'(RAM_CODE);
		bk_ena   = 1'b1;
		for (int i = 0; i < RAM_BYTES; i++)
			cpu_write(snes_pkg::bsram_addr_t'(i), snes_pkg::byte_t'($urandom));
		check_flag("bk_pending", bk_pending, 1'b1);
		run_save("first save");
		check_flag("bk_pending", bk_pending, 1'b0);

		// Load of the host image
		load_active   = 1'b1;
		bk_rd_sectors = 0;
		bk_load       = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		check_flag("bk_busy", bk_busy, 1'b1);
		wait_bk_done("load");
		load_active = 1'b0;
		check_count("load", bk_rd_sectors, SECTORS);
		for (int i = 0; i < RAM_BYTES; i++) begin
			model_ram[i] = i[0] ? image[i >> 1][15:8] : image[i >> 1][7:0];
			cpu_read(snes_pkg::bsram_addr_t'(i), model_ram[i]);
		end

		// Pending flag and the empty-RAM save
		check_flag("bk_pending", bk_pending, 1'b0);
		bk_ena = 1'b0;
		cpu_write(snes_pkg::bsram_addr_t'(5), snes_pkg::byte_t'($urandom));
		check_flag("bk_pending", bk_pending, 1'b0);
		bk_ena = 1'b1;
		cpu_write(snes_pkg::bsram_addr_t'(700), snes_pkg::byte_t'($urandom));
		check_flag("bk_pending", bk_pending, 1'b1);
		ram_size = '0;
		bk_save  = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		check_flag("bk_busy", bk_busy, 1'b0);
		// No sector write may be requested
		repeat (20) begin
			@(negedge clk_sys);
			check_flag("sd_wr", sd_wr, 1'b0);
		end
		check_flag("bk_pending", bk_pending, 1'b1);
		ram_size = snes_pkg::ram_size_t'(RAM_CODE);
		run_save("second save");
		check_flag("bk_pending", bk_pending, 1'b0);

		// Seek and stream
		stream_addr  = snes_pkg::msu_addr_t'($urandom % 32'h0010_0000);
		msu_next_lba = sd_pkg::lba_t'(stream_addr >> 9);
		msu_sectors  = 0;
		msu_addr     = stream_addr;
		msu_seek     = 1'b1;
		@(negedge clk_sys);
		msu_seek = 1'b0;
		check_flag("msu_data_busy", msu_data_busy, 1'b1);
		wait_stream_ready();
		check_count("fill before ready", msu_sectors, FILL_SECTORS);
		read_stream(stream_addr, STREAM_FIRST);
		stream_addr = stream_addr + STREAM_FIRST;

		// Save while the reader refills
		fork
			run_save("save during stream");
			read_stream(stream_addr, STREAM_SECOND);
		join

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
sd_pkg.sv
snes_pkg.sv
sector_if.sv
sector_arbiter.sv
backup_ram.sv
backup_sync.sv
msu_data_fifo.sv
msu_data_reader.sv
snes_sd_hub.sv
tb_snes_sd_hub.sv

//--- run.sh
#!/bin/sh
# Build and run the hub testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_snes_sd_hub -o tb_snes_sd_hub

./obj_dir/tb_snes_sd_hub | tee sim.log

grep -q "^=== PASS ===$" sim.log
echo "simulation passed"
